// ==== logic/post_pkg.sv ====
package post_pkg;

    localparam int word_width    = 4;
    localparam int seq_length    = 3;
    localparam int tap_depth     = 4;   // At least seq_length + 1
    localparam int history_depth = 3;
    localparam int t0_word       = 1;   // Middle word is decided
    localparam int err_width     = 8;
    localparam int chan_width    = 8;
    localparam int metric_width  = 20;
    localparam int num_hyp       = 4;

    localparam int win_size   = history_depth * word_width;
    localparam int hist_store = win_size - word_width;   // Words held in registers
    localparam int mid_base   = word_width * t0_word;    // First symbol of decided word
    localparam int fill_width = $clog2(history_depth + 1);
    localparam int pos_width  = $clog2(word_width);
    localparam int tsel_width = $clog2(tap_depth);

    typedef logic signed [err_width-1:0]  err_t;
    typedef logic signed [chan_width-1:0] chan_t;
    typedef logic [metric_width-1:0]      metric_t;
    typedef logic [1:0]                   hyp_t;

    localparam hyp_t hyp_none = 2'd0;   // No error
    localparam hyp_t hyp_pos  = 2'd1;   // Error at the position
    localparam hyp_t hyp_next = 2'd2;   // Error at the next position
    localparam hyp_t hyp_pair = 2'd3;   // Error pair

endpackage : post_pkg

// ==== logic/word_history.sv ====
module word_history import post_pkg::*; #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     shift,
    input  payload_t word [word_width-1:0],
    output payload_t window [win_size-1:0],
    output logic     full
);

    payload_t              store_q [hist_store-1:0];
    logic [fill_width-1:0] fill_cnt;

    // Oldest word at index 0, the word on the port fills the top slot
    always_comb begin
        for (int i = 0; i < hist_store; i++) begin
            window[i] = store_q[i];
        end
        for (int i = 0; i < word_width; i++) begin
            window[hist_store+i] = word[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            store_q  <= '{default: '0};
            fill_cnt <= '0;
        end else if (shift) begin
            for (int i = 0; i < hist_store; i++) begin
                store_q[i] <= window[i+word_width];   // Drop oldest word
            end
            if (fill_cnt != fill_width'(history_depth)) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
        end
    end

    // The word entering on this edge already counts
    assign full = (fill_cnt == fill_width'(history_depth)) ||
                  (shift && fill_cnt == fill_width'(history_depth - 1));

endmodule : word_history

// ==== logic/channel_table.sv ====
module channel_table import post_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  we,
    input  logic [pos_width-1:0]  pos,
    input  logic [tsel_width-1:0] tap,
    input  chan_t                 data,
    output chan_t                 taps [word_width-1:0][tap_depth-1:0]
);

    chan_t taps_q [word_width-1:0][tap_depth-1:0];

    // One tap per strobe, visible to the detector next cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            taps_q <= '{default: '{default: '0}};
        end else if (we) begin
            taps_q[pos][tap] <= data;
        end
    end

    always_comb begin
        for (int p = 0; p < word_width; p++) begin
            for (int j = 0; j < tap_depth; j++) begin
                taps[p][j] = taps_q[p][j];
            end
        end
    end

endmodule : channel_table

// ==== logic/sliding_detector.sv ====
module sliding_detector import post_pkg::*; (
    input  err_t  err_window [win_size-1:0],
    input  logic  bit_window [win_size-1:0],
    input  chan_t taps [word_width-1:0][tap_depth-1:0],
    output hyp_t  hyp [word_width-1:0]
);

    // Injected vectors, index v uses the taps of position v-1 and bit mid_base+v-1
    logic signed [chan_width:0]      inj [word_width:0][tap_depth-1:0];
    logic signed [err_width+1:0]     res [num_hyp-1:0][word_width-1:0][seq_length-1:0];
    logic signed [2*err_width+3:0]   sq [num_hyp-1:0][word_width-1:0][seq_length-1:0];
    metric_t                         metric [num_hyp-1:0][word_width-1:0];
    metric_t                         best [word_width-1:0];

    // Polarity follows the decided bit, vector 0 wraps to the last position's taps
    always_comb begin
        for (int v = 0; v <= word_width; v++) begin
            for (int j = 0; j < tap_depth; j++) begin
                inj[v][j] = bit_window[mid_base+v-1] ?
                            taps[(v+word_width-1)%word_width][j] :
                            -taps[(v+word_width-1)%word_width][j];
            end
        end
    end

    // Residuals after each hypothesis, squared and summed from zero
    always_comb begin
        for (int p = 0; p < word_width; p++) begin
            for (int k = 0; k < num_hyp; k++) begin
                metric[k][p] = '0;
            end
            for (int j = 0; j < seq_length; j++) begin
                res[hyp_none][p][j] = err_window[mid_base+p+j];
                res[hyp_pos][p][j]  = err_window[mid_base+p+j] + inj[p][j+1];
                res[hyp_next][p][j] = err_window[mid_base+p+j] + inj[p+1][j];
                res[hyp_pair][p][j] = err_window[mid_base+p+j] + inj[p+1][j]
                                      + inj[p][j+1];
                for (int k = 0; k < num_hyp; k++) begin
                    sq[k][p][j]  = res[k][p][j] * res[k][p][j];
                    metric[k][p] = metric[k][p] + metric_t'(sq[k][p][j]);
                end
            end
        end
    end

    // Strict less-than keeps the lower code on a tie
    always_comb begin
        for (int p = 0; p < word_width; p++) begin
            best[p] = metric[hyp_none][p];
            hyp[p]  = hyp_none;
            for (int k = 1; k < num_hyp; k++) begin
                if (metric[k][p] < best[p]) begin
                    best[p] = metric[k][p];
                    hyp[p]  = hyp_t'(k);
                end
            end
        end
    end

endmodule : sliding_detector

// ==== logic/error_corrector.sv ====
module error_corrector import post_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic shift,
    input  logic full,
    input  logic bit_window [win_size-1:0],
    input  hyp_t hyp [word_width-1:0],
    output logic out_valid,
    output logic out_bits [word_width-1:0],
    output hyp_t out_hyp [word_width-1:0]
);

    logic flip [word_width-1:0];
    logic fixed_bits [word_width-1:0];

    // Flip of bit p+1 from the last position falls outside the word
    always_comb begin
        flip[0] = hyp[0][0];
        for (int p = 1; p < word_width; p++) begin
            flip[p] = hyp[p][0] | hyp[p-1][1];
        end
        for (int p = 0; p < word_width; p++) begin
            fixed_bits[p] = bit_window[mid_base+p] ^ flip[p];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= shift & full;   // One pulse per counted word
        end
    end

    always_ff @(posedge clk) begin
        if (shift && full) begin
            out_bits <= fixed_bits;
            out_hyp  <= hyp;
        end
    end

endmodule : error_corrector

// ==== logic/post_processor_top.sv ====
module post_processor_top import post_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  err_t                  in_err [word_width-1:0],
    input  logic                  in_bits [word_width-1:0],
    input  logic                  cfg_we,
    input  logic [pos_width-1:0]  cfg_pos,
    input  logic [tsel_width-1:0] cfg_tap,
    input  chan_t                 cfg_data,
    output logic                  out_valid,
    output logic                  out_bits [word_width-1:0],
    output hyp_t                  out_hyp [word_width-1:0]
);

    err_t  err_window [win_size-1:0];
    logic  bit_window [win_size-1:0];
    logic  hist_full;
    chan_t taps [word_width-1:0][tap_depth-1:0];
    hyp_t  hyp [word_width-1:0];

    word_history #(
        .payload_t(err_t)
    ) i_err_history (
        .clk    (clk),
        .rst    (rst),
        .shift  (in_valid),
        .word   (in_err),
        .window (err_window),
        .full   ()               // Same fill count as the bit history
    );

    word_history #(
        .payload_t(logic)
    ) i_bit_history (
        .clk    (clk),
        .rst    (rst),
        .shift  (in_valid),
        .word   (in_bits),
        .window (bit_window),
        .full   (hist_full)
    );

    channel_table i_channel_table (
        .clk  (clk),
        .rst  (rst),
        .we   (cfg_we),
        .pos  (cfg_pos),
        .tap  (cfg_tap),
        .data (cfg_data),
        .taps (taps)
    );

    sliding_detector i_sliding_detector (
        .err_window (err_window),
        .bit_window (bit_window),
        .taps       (taps),
        .hyp        (hyp)
    );

    error_corrector i_error_corrector (
        .clk        (clk),
        .rst        (rst),
        .shift      (in_valid),
        .full       (hist_full),
        .bit_window (bit_window),
        .hyp        (hyp),
        .out_valid  (out_valid),
        .out_bits   (out_bits),
        .out_hyp    (out_hyp)
    );

endmodule : post_processor_top

// ==== tb/post_chk.sv ====
module post_chk (
    input logic clk,
    input logic rst,
    input logic in_valid,
    input logic out_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    a_valid_after_in: assert property (@(posedge clk) out_valid |-> $past(in_valid))
        else begin
            $error("out_valid high without an in_valid one cycle earlier");
            fail_count++;
        end

    a_low_after_rst: assert property (@(posedge clk) rst |=> !out_valid)
        else begin
            $error("out_valid high in the cycle after rst");
            fail_count++;
        end

    // A second pulse in a row needs a second strobe
    a_no_repeat: assert property (@(posedge clk) disable iff (rst)
        out_valid && !in_valid |=> !out_valid)
        else begin
            $error("out_valid high two cycles in a row without a new strobe");
            fail_count++;
        end

endmodule : post_chk

bind post_processor_top post_chk i_post_chk (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .out_valid (out_valid)
);

// ==== tb/tb_checker.sv ====
module tb_checker import post_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  err_t                  in_err [word_width-1:0],
    input  logic                  in_bits [word_width-1:0],
    input  logic                  cfg_we,
    input  logic [pos_width-1:0]  cfg_pos,
    input  logic [tsel_width-1:0] cfg_tap,
    input  chan_t                 cfg_data,
    input  logic                  out_valid,
    input  logic                  out_bits [word_width-1:0],
    input  hyp_t                  out_hyp [word_width-1:0],
    input  int                    test_num,
    output int                    check_count,
    output int                    error_count
);

    timeunit 1ns;
    timeprecision 1ps;

    int                      hist_e [hist_store];   // Oldest word first
    logic                    hist_b [hist_store];
    int                      win_e [win_size];
    logic                    win_b [win_size];
    int                      taps_m [word_width][tap_depth];
    int                      fill = 0;
    logic                    exp_valid = 1'b0;
    logic [word_width-1:0]   exp_bits;
    logic [2*word_width-1:0] exp_hyp;
    int                      cur_test = 0;
    int                      test_checks = 0;
    int                      test_errors = 0;
    int                      checks_total = 0;
    int                      errors_total = 0;

    assign check_count = checks_total;
    assign error_count = errors_total;

    function automatic string test_name(input int n);
        case (n)
            1: return "zero_channel";
            2: return "fill_and_reset";
            3: return "random_channel";
            4: return "planted_errors";
            5: return "idle_gaps";
            6: return "tap_rewrite";
            default: return "none";
        endcase
    endfunction

    // Vector v carries the taps of position v-1, sign set by the bit before it
    function automatic int inject(input int v, input int j);
        int t;
        t = taps_m[(v + word_width - 1) % word_width][j];
        return win_b[mid_base + v - 1] ? t : -t;
    endfunction

    // Returns the codes above the corrected middle word
    function automatic logic [3*word_width-1:0] predict();
        int                      m [num_hyp];
        int                      e;
        int                      vp;
        int                      vn;
        int                      best;
        logic [1:0]              code [word_width];
        logic                    flip;
        logic [word_width-1:0]   fixed;
        logic [2*word_width-1:0] codes;
        for (int p = 0; p < word_width; p++) begin
            for (int k = 0; k < num_hyp; k++) begin
                m[k] = 0;
            end
            for (int j = 0; j < seq_length; j++) begin
                e    = win_e[mid_base + p + j];
                vp   = inject(p, j + 1);
                vn   = inject(p + 1, j);
                m[0] = m[0] + e * e;
                m[1] = m[1] + (e + vp) * (e + vp);
                m[2] = m[2] + (e + vn) * (e + vn);
                m[3] = m[3] + (e + vp + vn) * (e + vp + vn);
            end
            best    = m[0];
            code[p] = 2'd0;
            for (int k = 1; k < num_hyp; k++) begin
                if (m[k] < best) begin   // Tie keeps the lower code
                    best    = m[k];
                    code[p] = 2'(k);
                end
            end
            codes[2*p +: 2] = code[p];
        end
        for (int p = 0; p < word_width; p++) begin
            flip = code[p][0];
            if (p > 0) begin
                flip = flip | code[p-1][1];
            end
            fixed[p] = win_b[mid_base + p] ^ flip;
        end
        return {codes, fixed};
    endfunction

    task automatic count_failure(input string msg);
        errors_total++;
        test_errors++;
        $display("%s", msg);
    endtask

    always @(posedge clk) begin
        logic [3*word_width-1:0] ref_word;
        logic [word_width-1:0]   got_bits;
        logic [2*word_width-1:0] got_hyp;
        if (test_num != cur_test) begin
            if (cur_test != 0) begin
                $display("Test %0d %s: %0d checks, %0d errors", cur_test,
                         test_name(cur_test), test_checks, test_errors);
            end
            cur_test    = test_num;
            test_checks = 0;
            test_errors = 0;
        end
        for (int p = 0; p < word_width; p++) begin
            got_bits[p]       = out_bits[p];
            got_hyp[2*p +: 2] = out_hyp[p];
        end
        if (exp_valid && !out_valid) begin
            count_failure($sformatf("%s: no out_valid one cycle after a counted word",
                                    test_name(cur_test)));
        end else if (!exp_valid && out_valid) begin
            count_failure($sformatf("%s: out_valid pulsed without a counted word",
                                    test_name(cur_test)));
        end else if (exp_valid) begin
            checks_total++;
            test_checks++;
            if (got_bits !== exp_bits) begin
                count_failure($sformatf("[ERROR] %s: out_bits expected %b, actual %b",
                                        test_name(cur_test), exp_bits, got_bits));
            end
            if (got_hyp !== exp_hyp) begin
                count_failure($sformatf("[ERROR] %s: out_hyp expected %h, actual %h",
                                        test_name(cur_test), exp_hyp, got_hyp));
            end
        end
        exp_valid = 1'b0;
        if (rst) begin
            fill   = 0;
            hist_e = '{default: 0};
            hist_b = '{default: 1'b0};
            taps_m = '{default: 0};
        end else begin
            if (in_valid) begin
                for (int i = 0; i < hist_store; i++) begin
                    win_e[i] = hist_e[i];
                    win_b[i] = hist_b[i];
                end
                for (int i = 0; i < word_width; i++) begin
                    win_e[hist_store + i] = int'(in_err[i]);
                    win_b[hist_store + i] = in_bits[i];
                end
                if (fill >= history_depth - 1) begin   // Entering word fills the window
                    ref_word  = predict();
                    exp_bits  = ref_word[word_width-1:0];
                    exp_hyp   = ref_word[3*word_width-1:word_width];
                    exp_valid = 1'b1;
                end
                for (int i = 0; i < hist_store; i++) begin
                    hist_e[i] = win_e[i + word_width];
                    hist_b[i] = win_b[i + word_width];
                end
                if (fill < history_depth) begin
                    fill++;
                end
            end
            if (cfg_we) begin
                taps_m[cfg_pos][cfg_tap] = int'(cfg_data);   // Seen from the next word on
            end
        end
    end

endmodule : tb_checker

// ==== tb/tb_top.sv ====
module tb_top import post_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int max_cycles = 2000;   // Tests take under 500 cycles

    logic                  clk;
    logic                  rst;
    logic                  in_valid;
    err_t                  in_err [word_width-1:0];
    logic                  in_bits [word_width-1:0];
    logic                  cfg_we;
    logic [pos_width-1:0]  cfg_pos;
    logic [tsel_width-1:0] cfg_tap;
    chan_t                 cfg_data;
    logic                  out_valid;
    logic                  out_bits [word_width-1:0];
    hyp_t                  out_hyp [word_width-1:0];
    int                    test_num;
    int                    check_count;
    int                    error_count;

    int                    seed;
    int                    cycle_count;
    int                    tap_model [word_width][tap_depth];
    logic [word_width-1:0] last_bits;

    post_processor_top i_post_processor_top (.*);

    tb_checker i_tb_checker (.*);

    always #50 clk = ~clk;

    task automatic send_word(input logic [err_width*word_width-1:0] errs,
                             input logic [word_width-1:0] bits);
        @(posedge clk);
        in_valid <= 1'b1;
        cfg_we   <= 1'b0;
        for (int i = 0; i < word_width; i++) begin
            in_err[i]  <= err_t'(errs[err_width*i +: err_width]);
            in_bits[i] <= bits[i];
        end
        last_bits = bits;
    endtask

    task automatic send_random_word();
        send_word((err_width*word_width)'($random(seed)), word_width'($random(seed)));
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
            cfg_we   <= 1'b0;
        end
    endtask

    task automatic write_tap(input int pos, input int tap, input int data);
        @(posedge clk);
        in_valid <= 1'b0;
        cfg_we   <= 1'b1;
        cfg_pos  <= pos_width'(pos);
        cfg_tap  <= tsel_width'(tap);
        cfg_data <= chan_t'(data);
        tap_model[pos][tap] = int'(chan_t'(data));
    endtask

    task automatic write_random_taps(input int limit);
        for (int p = 0; p < word_width; p++) begin
            for (int j = 0; j < tap_depth; j++) begin
                write_tap(p, j, $random(seed) % limit);
            end
        end
    endtask

    function automatic int planted_inj(input int v, input int j,
                                       input logic [word_width-1:0] b_prev,
                                       input logic [word_width-1:0] b_cur);
        int   t;
        logic sel;
        t   = tap_model[(v + word_width - 1) % word_width][j];
        sel = (v == 0) ? b_prev[word_width-1] : b_cur[v-1];
        return sel ? t : -t;
    endfunction

    // Errors cancel the chosen hypothesis, kind 1 single, 2 next, 3 pair
    task automatic plant_error(input int p, input int kind);
        logic [word_width-1:0]            b_prev;
        logic [word_width-1:0]            b_cur;
        int                               e [2*word_width];
        int                               vp;
        int                               vn;
        logic [err_width*word_width-1:0]  ea;
        logic [err_width*word_width-1:0]  eb;
        b_prev = last_bits;
        b_cur  = word_width'($random(seed));
        e      = '{default: 0};
        for (int j = 0; j < seq_length; j++) begin
            vp = planted_inj(p, j + 1, b_prev, b_cur);
            vn = planted_inj(p + 1, j, b_prev, b_cur);
            if (kind == 1) begin
                e[p+j] = -vp;
            end else if (kind == 2) begin
                e[p+j] = -vn;
            end else begin
                e[p+j] = -(vp + vn);
            end
        end
        for (int k = 0; k < word_width; k++) begin
            ea[err_width*k +: err_width] = err_width'(e[k]);
            eb[err_width*k +: err_width] = err_width'(e[k + word_width]);
        end
        send_word(ea, b_cur);
        send_word(eb, word_width'($random(seed)));   // Decides the planted word
        idle_cycles(1);
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", max_cycles);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        seed      = 32'h578c;
        clk       = 1'b0;
        rst       = 1'b1;
        in_valid  = 1'b0;
        cfg_we    = 1'b0;
        cfg_pos   = '0;
        cfg_tap   = '0;
        cfg_data  = '0;
        test_num  = 0;
        last_bits = '0;
        tap_model = '{default: 0};
        for (int i = 0; i < word_width; i++) begin
            in_err[i]  = '0;
            in_bits[i] = 1'b0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        test_num <= 1;   // Taps still cleared by reset
        repeat (20) send_random_word();
        idle_cycles(3);

        test_num <= 2;
        repeat (2) send_random_word();
        idle_cycles(3);
        repeat (5) send_random_word();
        @(posedge clk);
        rst      <= 1'b1;
        in_valid <= 1'b0;
        @(posedge clk);
        @(posedge clk);
        rst <= 1'b0;
        repeat (2) send_random_word();
        idle_cycles(3);
        repeat (4) send_random_word();
        idle_cycles(3);

        test_num <= 3;
        write_random_taps(128);
        repeat (200) send_random_word();
        idle_cycles(3);

        test_num <= 4;
        write_random_taps(32);   // Small taps keep planted errors in range
        for (int p = 0; p < word_width; p++) begin
            for (int kind = 1; kind < num_hyp; kind++) begin
                plant_error(p, kind);
            end
        end
        idle_cycles(3);

        test_num <= 5;
        repeat (30) begin
            send_random_word();
            idle_cycles($random(seed) & 3);
        end
        idle_cycles(3);

        test_num <= 6;
        repeat (6) begin
            repeat (2) send_random_word();
            write_tap($random(seed) & 3, $random(seed) & 3, $random(seed) % 128);
        end
        send_random_word();
        idle_cycles(3);

        test_num <= 0;
        idle_cycles(2);
        $display("Summary: 6 tests, %0d comparisons, %0d errors, %0d assertion failures",
                 check_count, error_count, i_post_processor_top.i_post_chk.fail_count);
        if (error_count == 0 && i_post_processor_top.i_post_chk.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : tb_top

// ==== project.f ====
logic/post_pkg.sv
logic/word_history.sv
logic/channel_table.sv
logic/sliding_detector.sv
logic/error_corrector.sv
logic/post_processor_top.sv
tb/post_chk.sv
tb/tb_checker.sv
tb/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
PASS_MSG  ?= *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
